//--- rtl/mmu_pkg.sv
package mmu_pkg;

    localparam logic [13:0] CSR_CRMD = 14'h000;
    localparam logic [13:0] CSR_ASID = 14'h018;
    localparam logic [13:0] CSR_DMW0 = 14'h180;
    localparam logic [13:0] CSR_DMW1 = 14'h181;

    localparam int INVTLB_OP_W = 5;

    localparam logic [5:0] PS_2M = 6'd21;  // anything else is taken as 4k

    // one page of the even/odd pair
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } page_t;

    typedef struct packed {
        logic        e;
        logic [9:0]  asid;
        logic        g;
        logic [5:0]  ps;     // 12 or 21
        logic [18:0] vppn;
        page_t       page0;
        page_t       page1;
    } tlb_entry_t;

    // same address word, cut for either page size
    typedef union packed {
        struct packed {
            logic [18:0] vppn;
            logic        odd;
            logic [11:0] offset;
        } pg4k;
        struct packed {
            logic [9:0]  vpn2m;
            logic        odd;
            logic [20:0] offset;
        } pg2m;
    } va_t;

    typedef struct packed {
        logic [22:0] rsv;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [2:0]  vseg;
        logic        rsv28;
        logic [2:0]  pseg;
        logic [18:0] rsv24_6;
        logic [1:0]  mat;
        logic        plv3;
        logic [1:0]  rsv2_1;
        logic        plv0;
    } dmw_t;

    typedef struct packed {
        logic refill;
        logic invalid;
        logic priv;
    } xlate_fault_t;

    typedef struct packed {
        logic [31:0]  pa;
        logic [1:0]   mat;
        xlate_fault_t fault;
    } xlate_rsp_t;

    typedef struct packed {
        logic [13:0] num;
        logic [31:0] wmask;
        logic [31:0] wdata;
    } csr_wr_t;

    // 2m pages compare only the top 10 bits of vppn
    function automatic logic vppn_hit(tlb_entry_t ent, va_t va);
        if (ent.ps == PS_2M) begin
            return ent.vppn[18:9] == va.pg2m.vpn2m;
        end
        return ent.vppn == va.pg4k.vppn;
    endfunction

endpackage

//--- rtl/mmu_csr.sv
`timescale 1ns/10ps

module mmu_csr (
    input  logic             aclk,
    input  logic             reset,
    input  logic             i_csr_we,
    input  mmu_pkg::csr_wr_t i_csr_wr,
    output mmu_pkg::crmd_t   o_crmd,
    output logic [9:0]       o_asid,
    output mmu_pkg::dmw_t    o_dmw0,
    output mmu_pkg::dmw_t    o_dmw1
);
    import mmu_pkg::*;

    localparam logic [31:0] CRMD_WMASK = 32'h0000_01ff;
    localparam logic [31:0] ASID_WMASK = 32'h0000_03ff;
    localparam logic [31:0] DMW_WMASK  = 32'hee00_0039;
    localparam logic [31:0] CRMD_RST   = 32'h0000_0008;  // da only

    crmd_t       crmd_q;
    logic [9:0]  asid_q;
    dmw_t        dmw0_q;
    dmw_t        dmw1_q;
    logic [31:0] asid_wr;

    // unmasked bits keep their value, bits outside keep stay zero
    function automatic logic [31:0] merge(logic [31:0] old, logic [31:0] keep, csr_wr_t wr);
        logic [31:0] m;
        m = wr.wmask & keep;
        return (old & ~m) | (wr.wdata & m);
    endfunction

    assign asid_wr = merge({22'b0, asid_q}, ASID_WMASK, i_csr_wr);

    always_ff @(posedge aclk) begin
        if (reset) begin
            crmd_q <= crmd_t'(CRMD_RST);
            asid_q <= '0;
            dmw0_q <= '0;
            dmw1_q <= '0;
        end else if (i_csr_we) begin
            case (i_csr_wr.num)
                CSR_CRMD: crmd_q <= crmd_t'(merge(crmd_q, CRMD_WMASK, i_csr_wr));
                CSR_ASID: asid_q <= asid_wr[9:0];
                CSR_DMW0: dmw0_q <= dmw_t'(merge(dmw0_q, DMW_WMASK, i_csr_wr));
                CSR_DMW1: dmw1_q <= dmw_t'(merge(dmw1_q, DMW_WMASK, i_csr_wr));
                default: ;  // not held here
            endcase
        end
    end

    assign o_crmd = crmd_q;
    assign o_asid = asid_q;
    assign o_dmw0 = dmw0_q;
    assign o_dmw1 = dmw1_q;

endmodule

//--- rtl/tlb_array.sv
`timescale 1ns/10ps

module tlb_array #(
    parameter int TLBNUM = 16
) (
    input  logic                              aclk,
    input  logic                              reset,
    input  logic                              i_we,
    input  logic [$clog2(TLBNUM)-1:0]         i_windex,
    input  mmu_pkg::tlb_entry_t               i_wentry,
    input  logic                              i_re,
    input  logic [$clog2(TLBNUM)-1:0]         i_rindex,
    input  logic                              i_inv_en,
    input  logic [mmu_pkg::INVTLB_OP_W-1:0]   i_inv_op,
    input  logic [9:0]                        i_inv_asid,
    input  mmu_pkg::va_t                      i_inv_va,
    output mmu_pkg::tlb_entry_t [TLBNUM-1:0]  o_entries,
    output logic                              o_rvalid,
    output mmu_pkg::tlb_entry_t               o_rentry
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(TLBNUM);

    tlb_entry_t [TLBNUM-1:0] entries_q;  // payload, e comes from e_q
    logic [TLBNUM-1:0]       e_q;
    logic [TLBNUM-1:0]       inv_hit;
    tlb_entry_t              rentry_q;
    logic                    rvalid_q;

    // which entries one invtlb op selects
    function automatic logic inv_match(
        tlb_entry_t             ent,
        logic [INVTLB_OP_W-1:0] op,
        logic [9:0]             asid,
        va_t                    va
    );
        logic asid_m;
        logic va_m;
        asid_m = ent.asid == asid;
        va_m   = vppn_hit(ent, va);
        case (op)
            0, 1:    return 1'b1;
            2:       return ent.g;
            3:       return !ent.g;
            4:       return !ent.g && asid_m;
            5:       return !ent.g && asid_m && va_m;
            6:       return (ent.g || asid_m) && va_m;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            inv_hit[i] = inv_match(entries_q[i], i_inv_op, i_inv_asid, i_inv_va);
        end
    end

    always_ff @(posedge aclk) begin
        if (i_we) begin
            entries_q[i_windex] <= i_wentry;
        end
    end

    // a write to the same slot beats invtlb
    always_ff @(posedge aclk) begin
        if (reset) begin
            e_q <= '0;
        end else begin
            for (int i = 0; i < TLBNUM; i++) begin
                if (i_we && i_windex == IDX_W'(i)) begin
                    e_q[i] <= i_wentry.e;
                end else if (i_inv_en && inv_hit[i]) begin
                    e_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            o_entries[i]   = entries_q[i];
            o_entries[i].e = e_q[i];
        end
    end

    // tlbrd sees the state before this edge
    always_ff @(posedge aclk) begin
        if (i_re) begin
            rentry_q <= o_entries[i_rindex];
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= i_re;
        end
    end

    assign o_rvalid = rvalid_q;
    assign o_rentry = rentry_q;

endmodule

//--- rtl/tlb_lookup.sv
`timescale 1ns/10ps

module tlb_lookup #(
    parameter int TLBNUM = 16
) (
    input  mmu_pkg::tlb_entry_t [TLBNUM-1:0] i_entries,
    input  mmu_pkg::va_t                     i_va,
    input  logic [9:0]                       i_asid,
    output logic                             o_found,
    output logic [5:0]                       o_ps,
    output mmu_pkg::page_t                   o_page
);
    import mmu_pkg::*;

    tlb_entry_t hit_ent;
    logic       odd;

    function automatic logic entry_hit(tlb_entry_t ent, va_t va, logic [9:0] asid);
        return ent.e && (ent.g || ent.asid == asid) && vppn_hit(ent, va);
    endfunction

    // walk downward so the lowest index is left standing
    always_comb begin
        o_found = 1'b0;
        hit_ent = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (entry_hit(i_entries[i], i_va, i_asid)) begin
                o_found = 1'b1;
                hit_ent = i_entries[i];
            end
        end
    end

    assign odd    = (hit_ent.ps == PS_2M) ? i_va.pg2m.odd : i_va.pg4k.odd;
    assign o_ps   = hit_ent.ps;
    assign o_page = odd ? hit_ent.page1 : hit_ent.page0;

endmodule

//--- rtl/addr_xlate.sv
`timescale 1ns/10ps

module addr_xlate #(
    parameter int TLBNUM    = 16,
    parameter int DATA_PORT = 0
) (
    input  logic                             aclk,
    input  logic                             reset,
    input  logic                             i_req,
    input  mmu_pkg::va_t                     i_va,
    input  mmu_pkg::crmd_t                   i_crmd,
    input  logic [9:0]                       i_asid,
    input  mmu_pkg::dmw_t                    i_dmw0,
    input  mmu_pkg::dmw_t                    i_dmw1,
    input  mmu_pkg::tlb_entry_t [TLBNUM-1:0] i_entries,
    output logic                             o_valid,
    output mmu_pkg::xlate_rsp_t              o_rsp
);
    import mmu_pkg::*;

    logic [31:0] va_raw;
    logic        tlb_found;
    logic [5:0]  tlb_ps;
    page_t       tlb_page;
    logic        dmw0_hit;
    logic        dmw1_hit;
    xlate_rsp_t  rsp_d;
    xlate_rsp_t  rsp_q;
    logic        valid_q;

    tlb_lookup #(
        .TLBNUM (TLBNUM)
    ) lookup_i (
        .i_entries (i_entries),
        .i_va      (i_va),
        .i_asid    (i_asid),
        .o_found   (tlb_found),
        .o_ps      (tlb_ps),
        .o_page    (tlb_page)
    );

    // only plv 0 and plv 3 have an enable bit
    function automatic logic dmw_hit(dmw_t w, logic [1:0] plv, logic [2:0] seg);
        return ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3)) && w.vseg == seg;
    endfunction

    assign va_raw   = i_va;
    assign dmw0_hit = dmw_hit(i_dmw0, i_crmd.plv, va_raw[31:29]);
    assign dmw1_hit = dmw_hit(i_dmw1, i_crmd.plv, va_raw[31:29]);

    always_comb begin
        rsp_d = '0;
        if (i_crmd.da) begin
            rsp_d.pa  = va_raw;
            rsp_d.mat = (DATA_PORT != 0) ? i_crmd.datm : i_crmd.datf;
        end else if (dmw0_hit) begin  // dmw0 has priority
            rsp_d.pa  = {i_dmw0.pseg, va_raw[28:0]};
            rsp_d.mat = i_dmw0.mat;
        end else if (dmw1_hit) begin
            rsp_d.pa  = {i_dmw1.pseg, va_raw[28:0]};
            rsp_d.mat = i_dmw1.mat;
        end else if (!tlb_found) begin
            rsp_d.fault.refill = 1'b1;  // pa left at zero
        end else begin
            rsp_d.pa  = (tlb_ps == PS_2M) ? {tlb_page.ppn[19:9], i_va.pg2m.offset}
                                          : {tlb_page.ppn, i_va.pg4k.offset};
            rsp_d.mat = tlb_page.mat;
            if (!tlb_page.v) begin
                rsp_d.fault.invalid = 1'b1;
            end else if (i_crmd.plv > tlb_page.plv) begin
                rsp_d.fault.priv = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (i_req) begin
            rsp_q <= rsp_d;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_req;  // one pulse per request
        end
    end

    assign o_valid = valid_q;
    assign o_rsp   = rsp_q;

endmodule

//--- rtl/mmu_top.sv
`timescale 1ns/10ps

module mmu_top #(
    parameter int TLBNUM = 16
) (
    input  logic                            aclk,
    input  logic                            reset,
    input  logic                            i_csr_we,
    input  mmu_pkg::csr_wr_t                i_csr_wr,
    input  logic                            i_tlb_we,
    input  logic [$clog2(TLBNUM)-1:0]       i_tlb_windex,
    input  mmu_pkg::tlb_entry_t             i_tlb_wentry,
    input  logic                            i_tlb_re,
    input  logic [$clog2(TLBNUM)-1:0]       i_tlb_rindex,
    output logic                            o_tlb_rvalid,
    output mmu_pkg::tlb_entry_t             o_tlb_rentry,
    input  logic                            i_inv_en,
    input  logic [mmu_pkg::INVTLB_OP_W-1:0] i_inv_op,
    input  logic [9:0]                      i_inv_asid,
    input  mmu_pkg::va_t                    i_inv_va,
    input  logic                            i_fetch_req,
    input  mmu_pkg::va_t                    i_fetch_va,
    output logic                            o_fetch_valid,
    output mmu_pkg::xlate_rsp_t             o_fetch_rsp,
    input  logic                            i_data_req,
    input  mmu_pkg::va_t                    i_data_va,
    output logic                            o_data_valid,
    output mmu_pkg::xlate_rsp_t             o_data_rsp
);
    import mmu_pkg::*;

    crmd_t                   crmd;
    logic [9:0]              asid;
    dmw_t                    dmw0;
    dmw_t                    dmw1;
    tlb_entry_t [TLBNUM-1:0] entries;

    mmu_csr csr_i (
        .aclk     (aclk),
        .reset    (reset),
        .i_csr_we (i_csr_we),
        .i_csr_wr (i_csr_wr),
        .o_crmd   (crmd),
        .o_asid   (asid),
        .o_dmw0   (dmw0),
        .o_dmw1   (dmw1)
    );

    tlb_array #(
        .TLBNUM (TLBNUM)
    ) tlb_i (
        .aclk       (aclk),
        .reset      (reset),
        .i_we       (i_tlb_we),
        .i_windex   (i_tlb_windex),
        .i_wentry   (i_tlb_wentry),
        .i_re       (i_tlb_re),
        .i_rindex   (i_tlb_rindex),
        .i_inv_en   (i_inv_en),
        .i_inv_op   (i_inv_op),
        .i_inv_asid (i_inv_asid),
        .i_inv_va   (i_inv_va),
        .o_entries  (entries),
        .o_rvalid   (o_tlb_rvalid),
        .o_rentry   (o_tlb_rentry)
    );

    // instruction side
    addr_xlate #(
        .TLBNUM    (TLBNUM),
        .DATA_PORT (0)
    ) fetch_xlate (
        .aclk      (aclk),
        .reset     (reset),
        .i_req     (i_fetch_req),
        .i_va      (i_fetch_va),
        .i_crmd    (crmd),
        .i_asid    (asid),
        .i_dmw0    (dmw0),
        .i_dmw1    (dmw1),
        .i_entries (entries),
        .o_valid   (o_fetch_valid),
        .o_rsp     (o_fetch_rsp)
    );

    addr_xlate #(
        .TLBNUM    (TLBNUM),
        .DATA_PORT (1)
    ) data_xlate (
        .aclk      (aclk),
        .reset     (reset),
        .i_req     (i_data_req),
        .i_va      (i_data_va),
        .i_crmd    (crmd),
        .i_asid    (asid),
        .i_dmw0    (dmw0),
        .i_dmw1    (dmw1),
        .i_entries (entries),
        .o_valid   (o_data_valid),
        .o_rsp     (o_data_rsp)
    );

endmodule

//--- test/mmu_tb.sv
`timescale 1ns/10ps

module mmu_tb;
    import mmu_pkg::*;

    localparam int TLBNUM     = 16;
    localparam int IDX_W      = $clog2(TLBNUM);
    localparam int MAX_LINES  = 64;
    localparam int MAX_FIELDS = 14;

    logic                   aclk;
    logic                   reset;
    logic                   i_csr_we;
    csr_wr_t                i_csr_wr;
    logic                   i_tlb_we;
    logic [IDX_W-1:0]       i_tlb_windex;
    tlb_entry_t             i_tlb_wentry;
    logic                   i_tlb_re;
    logic [IDX_W-1:0]       i_tlb_rindex;
    logic                   o_tlb_rvalid;
    tlb_entry_t             o_tlb_rentry;
    logic                   i_inv_en;
    logic [INVTLB_OP_W-1:0] i_inv_op;
    logic [9:0]             i_inv_asid;
    va_t                    i_inv_va;
    logic                   i_fetch_req;
    va_t                    i_fetch_va;
    logic                   o_fetch_valid;
    xlate_rsp_t             o_fetch_rsp;
    logic                   i_data_req;
    va_t                    i_data_va;
    logic                   o_data_valid;
    xlate_rsp_t             o_data_rsp;

    byte         ops   [MAX_LINES];
    string       names [MAX_LINES];
    logic [31:0] flds  [MAX_LINES][MAX_FIELDS];
    int          nlines     = 0;
    int          cycles     = 0;
    int          limit      = 100;
    int          mismatches = 0;
    int          failures   = 0;
    logic [15:0] lfsr       = 16'd63945;

    mmu_top #(
        .TLBNUM (TLBNUM)
    ) mmu_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic int field_count(byte op);
        case (op)
            "C", "I": return 3;
            "F", "D": return 4;
            "W": return 14;
            "R": return 7;
            "X": return 5;
            default: return -1;
        endcase
    endfunction

    task automatic load_golden();
        int          fd;
        int          n;
        int          rc;
        string       tok;
        string       nm;
        logic [31:0] v;
        fd = $fopen("test/mmu_golden.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("cannot open test/mmu_golden.txt");
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                rc = $fgets(nm, fd);  // rest of a comment line
                continue;
            end
            n = field_count(tok[0]);
            if (n < 0 || nlines == MAX_LINES) begin
                failures++;
                $display("golden file holds an unknown op or too many lines at %s", tok);
                break;
            end
            rc = $fscanf(fd, "%s", nm);
            ops[nlines]   = tok[0];
            names[nlines] = nm;
            for (int k = 0; k < n; k++) begin
                rc = $fscanf(fd, "%h", v);
                if (rc != 1) begin
                    failures++;
                    $display("golden line %s is missing a field", nm);
                end
                flds[nlines][k] = v;
            end
            nlines++;
        end
        $fclose(fd);
    endtask

    task automatic compare(string name, logic [95:0] exp, logic [95:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic expect_pulse(string name, logic valid);
        assert (valid === 1'b1) else begin
            failures++;
            $display("%s: valid pulse missing one cycle after the request", name);
        end
    endtask

    task automatic expect_idle(string name, logic valid);
        assert (valid === 1'b0) else begin
            failures++;
            $display("%s: valid stayed high for more than one cycle", name);
        end
    endtask

    task automatic write_csr(int i);
        @(posedge aclk);
        i_csr_we <= 1'b1;
        i_csr_wr <= {flds[i][0][13:0], flds[i][1], flds[i][2]};
        @(posedge aclk);
        i_csr_we <= 1'b0;
    endtask

    task automatic write_entry(int i);
        tlb_entry_t ent;
        ent.e          = flds[i][1][0];
        ent.asid       = flds[i][2][9:0];
        ent.g          = flds[i][3][0];
        ent.ps         = flds[i][4][5:0];
        ent.vppn       = flds[i][5][18:0];
        ent.page0.ppn  = flds[i][6][19:0];
        ent.page0.plv  = flds[i][7][1:0];
        ent.page0.mat  = flds[i][8][1:0];
        ent.page0.d    = 1'b0;
        ent.page0.v    = flds[i][9][0];
        ent.page1.ppn  = flds[i][10][19:0];
        ent.page1.plv  = flds[i][11][1:0];
        ent.page1.mat  = flds[i][12][1:0];
        ent.page1.d    = 1'b0;
        ent.page1.v    = flds[i][13][0];
        @(posedge aclk);
        i_tlb_we     <= 1'b1;
        i_tlb_windex <= flds[i][0][IDX_W-1:0];
        i_tlb_wentry <= ent;
        @(posedge aclk);
        i_tlb_we <= 1'b0;
    endtask

    task automatic read_entry(int i);
        logic [70:0] exp;
        exp = {flds[i][1][0], flds[i][2][9:0], flds[i][3][0], flds[i][4][18:0],
               flds[i][5][19:0], flds[i][6][19:0]};
        @(posedge aclk);
        i_tlb_re     <= 1'b1;
        i_tlb_rindex <= flds[i][0][IDX_W-1:0];
        @(posedge aclk);
        i_tlb_re <= 1'b0;
        @(negedge aclk);
        expect_pulse(names[i], o_tlb_rvalid);
        compare(names[i], exp, {o_tlb_rentry.e, o_tlb_rentry.asid, o_tlb_rentry.g,
                                o_tlb_rentry.vppn, o_tlb_rentry.page0.ppn,
                                o_tlb_rentry.page1.ppn});
        @(negedge aclk);
        expect_idle(names[i], o_tlb_rvalid);
    endtask

    task automatic invalidate(int i);
        @(posedge aclk);
        i_inv_en   <= 1'b1;
        i_inv_op   <= flds[i][0][INVTLB_OP_W-1:0];
        i_inv_asid <= flds[i][1][9:0];
        i_inv_va   <= flds[i][2];
        @(posedge aclk);
        i_inv_en <= 1'b0;
    endtask

    task automatic translate_one(string name, bit data_port, logic [31:0] va, xlate_rsp_t exp);
        @(posedge aclk);
        if (data_port) begin
            i_data_req <= 1'b1;
            i_data_va  <= va;
        end else begin
            i_fetch_req <= 1'b1;
            i_fetch_va  <= va;
        end
        @(posedge aclk);
        i_fetch_req <= 1'b0;
        i_data_req  <= 1'b0;
        @(negedge aclk);
        if (data_port) begin
            expect_pulse(name, o_data_valid);
            compare(name, exp, o_data_rsp);
        end else begin
            expect_pulse(name, o_fetch_valid);
            compare(name, exp, o_fetch_rsp);
        end
        @(negedge aclk);
        expect_idle(name, data_port ? o_data_valid : o_fetch_valid);
    endtask

    // both ports back to back with each answer checked as the next request goes out
    task automatic random_batch(int i);
        logic [31:0] off;
        logic [31:0] va;
        xlate_rsp_t  exp;
        xlate_rsp_t  prev;
        string       tag;
        exp  = '0;
        prev = '0;
        for (int k = 0; k <= int'(flds[i][2]); k++) begin
            @(posedge aclk);
            if (k < int'(flds[i][2])) begin
                draw_bits(flds[i][1], off);
                va  = flds[i][0] + off;
                exp = {flds[i][3] + off, flds[i][4][1:0], 3'b000};  // page base plus offset
                i_fetch_req <= 1'b1;
                i_fetch_va  <= va;
                i_data_req  <= 1'b1;
                i_data_va   <= va;
            end else begin
                i_fetch_req <= 1'b0;
                i_data_req  <= 1'b0;
            end
            @(negedge aclk);
            if (k > 0) begin
                tag = $sformatf("%s[%0d]", names[i], k - 1);
                expect_pulse(tag, o_fetch_valid);
                expect_pulse(tag, o_data_valid);
                compare(tag, prev, o_fetch_rsp);
                compare(tag, prev, o_data_rsp);
            end
            prev = exp;
        end
    endtask

    task automatic run_line(int i);
        xlate_rsp_t exp;
        exp = {flds[i][1], flds[i][2][1:0], flds[i][3][2:0]};
        case (ops[i])
            "C": write_csr(i);
            "W": write_entry(i);
            "R": read_entry(i);
            "I": invalidate(i);
            "F": translate_one(names[i], 1'b0, flds[i][0], exp);
            "D": translate_one(names[i], 1'b1, flds[i][0], exp);
            "X": random_batch(i);
            default: ;
        endcase
    endtask

    initial begin
        reset        = 1'b1;
        i_csr_we     = 1'b0;
        i_csr_wr     = '0;
        i_tlb_we     = 1'b0;
        i_tlb_windex = '0;
        i_tlb_wentry = '0;
        i_tlb_re     = 1'b0;
        i_tlb_rindex = '0;
        i_inv_en     = 1'b0;
        i_inv_op     = '0;
        i_inv_asid   = '0;
        i_inv_va     = '0;
        i_fetch_req  = 1'b0;
        i_fetch_va   = '0;
        i_data_req   = 1'b0;
        i_data_va    = '0;
        load_golden();
        limit = 4 * nlines + 100;
        for (int i = 0; i < nlines; i++) begin
            if (ops[i] == "X") begin
                limit += int'(flds[i][2]);
            end
        end
        repeat (10) @(posedge aclk);
        reset <= 1'b0;
        for (int i = 0; i < nlines; i++) begin
            run_line(i);
        end
        @(posedge aclk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- test/mmu_golden.txt
# all hex. C num wmask wdata | W idx e asid g ps vppn ppn0 plv0 mat0 v0 ppn1 plv1 mat1 v1
# R idx e asid g vppn ppn0 ppn1 | I op asid va | F,D va pa mat fault | X va ps count pa mat
F reset_fetch 12345678 12345678 0 0
D reset_data 9abcdef0 9abcdef0 0 0
C crmd_dat 0000 ffffffff 00000128
F da_fetch_mat 00001000 00001000 1 0
D da_data_mat 00002000 00002000 2 0
C crmd_pg 0000 ffffffff 00000010
C dmw0_set 0180 ffffffff 82000011
C dmw1_set 0181 ffffffff a0000029
F dmw0_fetch 81234567 21234567 1 0
D dmw1_data a7654321 07654321 2 0
C dmw1_seg4 0181 ffffffff 80000029
D dmw_both 81234567 21234567 1 0
C dmw0_plv0_off 0180 00000001 00000000
F dmw0_disabled 81234567 01234567 2 0
C asid_5 0018 ffffffff 00000005
W ent0_4k 0 1 005 0 0c 00200 12340 0 1 1 56781 0 1 1
W ent1_2m_global 1 1 007 1 15 00400 00a00 3 0 1 00e00 3 2 1
W ent2_asid7 2 1 007 0 0c 00600 11110 0 1 1 11111 0 1 1
W ent3_fault 3 1 005 0 0c 00800 22220 0 1 0 22221 0 1 1
R rd_ent1 1 1 007 1 00400 00a00 00e00
F tlb4k_even 00400abc 12340abc 1 0
D tlb4k_odd 00401def 56781def 1 0
F tlb2m_even 00812345 00a12345 0 0
D tlb2m_odd 00a54321 00e54321 2 0
X rand4k_odd 00401000 0c 10 56781000 1
X rand2m_even 00800000 15 10 00a00000 0
F asid_miss 00c00123 00000000 0 4
D unmapped 02000000 00000000 0 4
D invalid 01000010 22220010 1 2
C crmd_plv3 0000 ffffffff 00000013
D priv 01001020 22221020 1 1
I inv6 6 007 00c00000
R rd_inv6 2 0 007 0 00600 11110 11111
I inv5 5 005 00400000
R rd_inv5 0 0 005 0 00200 12340 56781
I inv2 2 000 00000000
F inv2_refill 00812345 00000000 0 4
I inv4 4 005 00000000
R rd_inv4 3 0 005 0 00800 22220 22221
W ent1_again 1 1 007 1 15 00400 00a00 3 0 1 00e00 3 2 1
W ent2_again 2 1 007 0 0c 00600 11110 0 1 1 11111 0 1 1
I inv3 3 000 00000000
R rd_inv3 2 0 007 0 00600 11110 11111
F inv3_keep 00812345 00a12345 0 0
I inv1 1 000 00000000
F inv1_refill 00812345 00000000 0 4
W ent0_again 0 1 005 0 0c 00200 12340 0 1 1 56781 0 1 1
I inv0 0 000 00000000
R rd_inv0 0 0 005 0 00200 12340 56781

//--- flist.f
rtl/mmu_pkg.sv
rtl/mmu_csr.sv
rtl/tlb_array.sv
rtl/tlb_lookup.sv
rtl/addr_xlate.sv
rtl/mmu_top.sv
test/mmu_tb.sv
